// File: common/cpu_dma_pkg.sv
// CPU DMA transmit queue constants, width types, bus structs and FSM state enums
package cpu_dma_pkg;

   ////////////////////////////////////////////////////////////
   // Bus widths and protocol constants
   ////////////////////////////////////////////////////////////
   localparam int DATA_WIDTH     = 64;
   localparam int CTRL_WIDTH     = 8;
   localparam int DMA_DATA_WIDTH = 32;
   localparam int DMA_CTRL_WIDTH = 4;

   // Control value of a module header word
   localparam logic [CTRL_WIDTH-1:0] HDR_CTRL = 8'hff;

   localparam int MAX_PKT_SIZE = 2048;

   // FIFO sizing
   localparam int TX_FIFO_DEPTH_BITS   = 8;
   localparam int TX_FIFO_AFULL_MARGIN = 4;
   localparam int LEN_FIFO_DEPTH_BITS  = 3;

   ////////////////////////////////////////////////////////////
   // Width types
   ////////////////////////////////////////////////////////////
   typedef logic [11:0] pkt_byte_len_t;
   typedef logic [8:0]  pkt_word_len_t;
   typedef logic [5:0]  pkt_count_t;
   typedef logic [15:0] stat_count_t;

   // One word of the 64-bit input path
   typedef struct packed {
      logic [CTRL_WIDTH-1:0] ctrl;
      logic [DATA_WIDTH-1:0] data;
   } in_word_t;

   // One word as seen by the DMA reader
   typedef struct packed {
      logic [DMA_CTRL_WIDTH-1:0] ctrl;
      logic [DMA_DATA_WIDTH-1:0] data;
   } dma_word_t;

   // Single-cycle queue event pulses
   typedef struct packed {
      logic stored;
      logic removed;
      logic underrun;
      logic overrun;
   } tx_q_events_t;

   typedef struct packed {
      stat_count_t   pkts_stored;
      stat_count_t   pkts_removed;
      stat_count_t   underruns;
      stat_count_t   overruns;
      pkt_byte_len_t last_byte_len;
      pkt_word_len_t last_word_len;
   } tx_q_stats_t;

   typedef enum logic {IN_HDR, IN_BODY} in_state_t;
   typedef enum logic {OUT_HDR, OUT_BODY} out_state_t;

endpackage

// File: src/fallthrough_fifo.sv
// Parameterized first-word-fall-through synchronous FIFO with full, almost-full and empty
`timescale 1ns/1ps

module fallthrough_fifo #(
   parameter int WIDTH      = 72,
   parameter int DEPTH_BITS = 8
) (
   input  logic             clk,
   input  logic             reset,
   input  logic [WIDTH-1:0] din,
   input  logic             wr_en,
   input  logic             rd_en,
   output logic [WIDTH-1:0] dout,
   output logic             full,
   output logic             almost_full,
   output logic             empty
);
   import cpu_dma_pkg::*;

   localparam int DEPTH = 1 << DEPTH_BITS;

   logic [WIDTH-1:0]      mem [DEPTH];
   logic [DEPTH_BITS-1:0] wr_ptr;
   logic [DEPTH_BITS-1:0] rd_ptr;
   logic [DEPTH_BITS:0]   count;
   logic                  wr_ok;
   logic                  rd_ok;

   // Full writes are dropped, empty reads ignored
   assign wr_ok = wr_en && !full;
   assign rd_ok = rd_en && !empty;

   // Head entry always on the output
   assign dout = mem[rd_ptr];

   // Count reaches DEPTH only when its top bit is set
   assign full        = count[DEPTH_BITS];
   assign empty       = (count == '0);
   assign almost_full = (DEPTH - int'(count)) <= TX_FIFO_AFULL_MARGIN;

   ////////////////////////////////////////////////////////////
   // Storage
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (wr_ok) begin
         mem[wr_ptr] <= din;
      end
   end

   ////////////////////////////////////////////////////////////
   // Pointers and occupancy
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_ok) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_ok) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         count <= count + {{DEPTH_BITS{1'b0}}, wr_ok} - {{DEPTH_BITS{1'b0}}, rd_ok};
      end
   end

   // Pointers hold on a rejected access
   assert property (@(posedge clk) disable iff (reset)
      (rd_en && empty) |=> (rd_ptr == $past(rd_ptr)));
   assert property (@(posedge clk) disable iff (reset)
      (wr_en && full) |=> (wr_ptr == $past(wr_ptr)));

endmodule

// File: cpu_dma_tx_queue/tx_word_fifo.sv
// 64-to-32 width-change FIFO with little-endian reordering and dead half skip
`timescale 1ns/1ps

module tx_word_fifo (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  wr,
   input  cpu_dma_pkg::in_word_t wr_word,
   input  logic                  rd,
   input  logic                  in_body,
   output cpu_dma_pkg::dma_word_t rd_word,
   output logic                  full,
   output logic                  almost_full,
   output logic                  empty
);
   import cpu_dma_pkg::*;

   localparam int ENTRY_WIDTH = 2 * (DMA_CTRL_WIDTH + DMA_DATA_WIDTH);

   logic [DATA_WIDTH-1:0]  le_data;
   logic [CTRL_WIDTH-1:0]  le_ctrl;
   dma_word_t              lo_in;
   dma_word_t              hi_in;
   dma_word_t              lo_out;
   dma_word_t              hi_out;
   logic [ENTRY_WIDTH-1:0] fifo_dout;
   logic                   fifo_empty;
   logic                   half_sel;
   logic                   rd_ok;
   logic                   realign;
   logic                   pop;

   ////////////////////////////////////////////////////////////
   // Byte and control reordering, big to little endian
   ////////////////////////////////////////////////////////////
   always_comb begin
      for (int k = 0; k < CTRL_WIDTH; k++) begin
         le_data[8*k +: 8] = wr_word.data[DATA_WIDTH-8-8*k +: 8];
         le_ctrl[k]        = wr_word.ctrl[CTRL_WIDTH-1-k];
      end
   end

   // Half 0 holds input bytes 0 to 3
   assign lo_in.ctrl = le_ctrl[DMA_CTRL_WIDTH-1:0];
   assign lo_in.data = le_data[DMA_DATA_WIDTH-1:0];
   assign hi_in.ctrl = le_ctrl[CTRL_WIDTH-1:DMA_CTRL_WIDTH];
   assign hi_in.data = le_data[DATA_WIDTH-1:DMA_DATA_WIDTH];

   fallthrough_fifo #(
      .WIDTH      (ENTRY_WIDTH),
      .DEPTH_BITS (TX_FIFO_DEPTH_BITS)
   ) u_word_fifo (
      .clk         (clk),
      .reset       (reset),
      .din         ({hi_in, lo_in}),
      .wr_en       (wr),
      .rd_en       (pop),
      .dout        (fifo_dout),
      .full        (full),
      .almost_full (almost_full),
      .empty       (fifo_empty)
   );

   assign {hi_out, lo_out} = fifo_dout;
   assign rd_word = half_sel ? hi_out : lo_out;
   assign empty   = fifo_empty;

   ////////////////////////////////////////////////////////////
   // Half select and entry pop
   ////////////////////////////////////////////////////////////
   assign rd_ok = rd && !fifo_empty;

   // Stray upper half outside a packet body is dropped
   assign realign = !in_body && half_sel && !fifo_empty;

   // Early end marker in half 0 pops the whole entry
   assign pop = (rd_ok && (half_sel || (lo_out.ctrl != '0))) || realign;

   always_ff @(posedge clk) begin
      if (reset) begin
         half_sel <= 1'b0;
      end else if (pop) begin
         half_sel <= 1'b0;
      end else if (rd_ok) begin
         half_sel <= 1'b1;
      end
   end

endmodule

// File: cpu_dma_tx_queue/cpu_dma_tx_queue.sv
// CPU DMA transmit queue with input and output FSMs, length FIFO, occupancy and events
`timescale 1ns/1ps

module cpu_dma_tx_queue (
   input  logic                       clk,
   input  logic                       reset,
   input  cpu_dma_pkg::in_word_t      in_word,
   input  logic                       in_wr,
   output logic                       in_rdy,
   input  logic                       tx_queue_en,
   input  logic                       cpu_q_dma_rd,
   output cpu_dma_pkg::dma_word_t     cpu_q_dma_rd_word,
   output logic                       cpu_q_dma_pkt_avail,
   output cpu_dma_pkg::tx_q_events_t  events,
   output logic                       hdr_seen,
   output cpu_dma_pkg::pkt_byte_len_t hdr_byte_len,
   output cpu_dma_pkg::pkt_word_len_t hdr_word_len
);
   import cpu_dma_pkg::*;

   in_state_t     in_state;
   out_state_t    out_state;
   out_state_t    out_state_nxt;

   pkt_byte_len_t cur_byte_len;
   pkt_word_len_t cur_word_len;
   pkt_byte_len_t len_out;
   pkt_count_t    pkt_count;

   dma_word_t     fifo_word;
   logic          word_wr;
   logic          word_rd;
   logic          word_full;
   logic          word_afull;
   logic          word_empty;
   logic          len_wr;
   logic          len_rd;
   logic          len_full;
   logic          len_empty;
   logic          is_hdr;
   logic          pkt_end;
   logic          pkt_done;

   logic          stored_q;
   logic          removed_q;
   logic          underrun_q;
   logic          overrun_q;

   ////////////////////////////////////////////////////////////
   // Buffers
   ////////////////////////////////////////////////////////////
   tx_word_fifo u_tx_word_fifo (
      .clk         (clk),
      .reset       (reset),
      .wr          (word_wr),
      .wr_word     (in_word),
      .rd          (word_rd),
      .in_body     (out_state == OUT_BODY),
      .rd_word     (fifo_word),
      .full        (word_full),
      .almost_full (word_afull),
      .empty       (word_empty)
   );

   // One byte length per queued packet
   fallthrough_fifo #(
      .WIDTH      ($bits(pkt_byte_len_t)),
      .DEPTH_BITS (LEN_FIFO_DEPTH_BITS)
   ) u_len_fifo (
      .clk         (clk),
      .reset       (reset),
      .din         (cur_byte_len),
      .wr_en       (len_wr),
      .rd_en       (len_rd),
      .dout        (len_out),
      .full        (len_full),
      .almost_full (),
      .empty       (len_empty)
   );

   assign in_rdy = !word_afull && !len_full;

   ////////////////////////////////////////////////////////////
   // Input FSM
   ////////////////////////////////////////////////////////////
   assign cur_byte_len = in_word.data[$bits(pkt_byte_len_t)-1:0];
   // Round up to whole 64-bit words
   assign cur_word_len = pkt_word_len_t'(cur_byte_len[11:3]) +
                         pkt_word_len_t'(|cur_byte_len[2:0]);

   assign is_hdr  = (in_word.ctrl == HDR_CTRL);
   assign len_wr  = in_wr && (in_state == IN_HDR) && is_hdr;
   // Headerless body start is accepted, other stray words are dropped
   assign word_wr = in_wr && ((in_state == IN_BODY) || (in_word.ctrl == '0));
   assign pkt_end = in_wr && (in_state == IN_BODY) && (in_word.ctrl != '0);

   always_ff @(posedge clk) begin
      if (reset) begin
         in_state <= IN_HDR;
         hdr_seen <= 1'b0;
      end else begin
         hdr_seen <= len_wr;
         if (pkt_end) begin
            in_state <= IN_HDR;
         end else if (len_wr || (in_wr && (in_state == IN_HDR) && (in_word.ctrl == '0))) begin
            // Header or headerless body word opens the body
            in_state <= IN_BODY;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (len_wr) begin
         hdr_byte_len <= cur_byte_len;
         hdr_word_len <= cur_word_len;
      end
   end

   ////////////////////////////////////////////////////////////
   // Output FSM
   ////////////////////////////////////////////////////////////
   always_comb begin
      out_state_nxt     = out_state;
      cpu_q_dma_rd_word = '0;
      len_rd            = 1'b0;
      word_rd           = 1'b0;
      pkt_done          = 1'b0;
      case (out_state)
         OUT_HDR: begin
            // Length word first
            cpu_q_dma_rd_word.data = DMA_DATA_WIDTH'(len_out);
            if (cpu_q_dma_rd && !len_empty) begin
               len_rd        = 1'b1;
               out_state_nxt = OUT_BODY;
            end
         end
         OUT_BODY: begin
            cpu_q_dma_rd_word = fifo_word;
            word_rd           = cpu_q_dma_rd;
            if (cpu_q_dma_rd && !word_empty && (fifo_word.ctrl != '0)) begin
               pkt_done      = 1'b1;
               out_state_nxt = OUT_HDR;
            end
         end
         default: out_state_nxt = OUT_HDR;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         out_state <= OUT_HDR;
      end else begin
         out_state <= out_state_nxt;
      end
   end

   ////////////////////////////////////////////////////////////
   // Event pulses and occupancy
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         stored_q   <= 1'b0;
         removed_q  <= 1'b0;
         underrun_q <= 1'b0;
         overrun_q  <= 1'b0;
      end else begin
         stored_q   <= pkt_end;
         removed_q  <= pkt_done;
         underrun_q <= cpu_q_dma_rd && word_empty;
         overrun_q  <= in_wr && word_full;
      end
   end

   assign events = '{stored: stored_q, removed: removed_q,
                     underrun: underrun_q, overrun: overrun_q};

   // Packets complete but with header not yet read
   always_ff @(posedge clk) begin
      if (reset) begin
         pkt_count <= '0;
      end else begin
         case ({stored_q, len_rd})
            2'b10:   pkt_count <= pkt_count + 1'b1;
            2'b01:   pkt_count <= pkt_count - 1'b1;
            default: pkt_count <= pkt_count;
         endcase
      end
   end

   assign cpu_q_dma_pkt_avail = tx_queue_en && (pkt_count != '0);

   // Header read only for a completed packet
   assert property (@(posedge clk) disable iff (reset)
      len_rd |-> ((pkt_count != '0) || stored_q));

   // Only body words may overrun a filling word FIFO
   assert property (@(posedge clk) disable iff (reset)
      (in_wr && !in_rdy) |-> ((in_state == IN_BODY) && !len_full));

endmodule

// File: src/tx_queue_stats.sv
// Saturating transmit queue event counters and last header length registers
`timescale 1ns/1ps

module tx_queue_stats (
   input  logic                       clk,
   input  logic                       reset,
   input  cpu_dma_pkg::tx_q_events_t  events,
   input  logic                       hdr_seen,
   input  cpu_dma_pkg::pkt_byte_len_t hdr_byte_len,
   input  cpu_dma_pkg::pkt_word_len_t hdr_word_len,
   output cpu_dma_pkg::tx_q_stats_t   stats
);
   import cpu_dma_pkg::*;

   // Counter sticks at all ones
   function automatic stat_count_t sat_inc(input stat_count_t cnt, input logic ev);
      stat_count_t res;
      res = cnt;
      if (ev && (cnt != '1)) begin
         res = cnt + 1'b1;
      end
      return res;
   endfunction

   ////////////////////////////////////////////////////////////
   // Event counters
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         stats.pkts_stored  <= '0;
         stats.pkts_removed <= '0;
         stats.underruns    <= '0;
         stats.overruns     <= '0;
      end else begin
         stats.pkts_stored  <= sat_inc(stats.pkts_stored, events.stored);
         stats.pkts_removed <= sat_inc(stats.pkts_removed, events.removed);
         stats.underruns    <= sat_inc(stats.underruns, events.underrun);
         stats.overruns     <= sat_inc(stats.overruns, events.overrun);
      end
   end

   ////////////////////////////////////////////////////////////
   // Last header lengths
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         stats.last_byte_len <= '0;
         stats.last_word_len <= '0;
      end else if (hdr_seen) begin
         stats.last_byte_len <= hdr_byte_len;
         stats.last_word_len <= hdr_word_len;
      end
   end

endmodule

// File: src/cpu_dma_tx_top.sv
// Top level of the CPU DMA transmit path, queue plus statistics
`timescale 1ns/1ps

module cpu_dma_tx_top (
   input  logic                     clk,
   input  logic                     reset,
   input  cpu_dma_pkg::in_word_t    in_word,
   input  logic                     in_wr,
   output logic                     in_rdy,
   input  logic                     tx_queue_en,
   input  logic                     cpu_q_dma_rd,
   output cpu_dma_pkg::dma_word_t   cpu_q_dma_rd_word,
   output logic                     cpu_q_dma_pkt_avail,
   output cpu_dma_pkg::tx_q_stats_t stats
);
   import cpu_dma_pkg::*;

   tx_q_events_t  events;
   logic          hdr_seen;
   pkt_byte_len_t hdr_byte_len;
   pkt_word_len_t hdr_word_len;

   cpu_dma_tx_queue u_tx_queue (
      .clk                 (clk),
      .reset               (reset),
      .in_word             (in_word),
      .in_wr               (in_wr),
      .in_rdy              (in_rdy),
      .tx_queue_en         (tx_queue_en),
      .cpu_q_dma_rd        (cpu_q_dma_rd),
      .cpu_q_dma_rd_word   (cpu_q_dma_rd_word),
      .cpu_q_dma_pkt_avail (cpu_q_dma_pkt_avail),
      .events              (events),
      .hdr_seen            (hdr_seen),
      .hdr_byte_len        (hdr_byte_len),
      .hdr_word_len        (hdr_word_len)
   );

   // Event pulses land in the counters one cycle later
   tx_queue_stats u_tx_stats (
      .clk          (clk),
      .reset        (reset),
      .events       (events),
      .hdr_seen     (hdr_seen),
      .hdr_byte_len (hdr_byte_len),
      .hdr_word_len (hdr_word_len),
      .stats        (stats)
   );

endmodule

// File: test/tb_cpu_dma_tx.sv
// Testbench for the CPU DMA transmit path with random packets and a reference model
`timescale 1ns/1ps

module tb_cpu_dma_tx;
   import cpu_dma_pkg::*;

   localparam int NUM_PKTS  = 40;
   localparam int FILL_PKTS = 7;
   localparam int TIMEOUT   = NUM_PKTS * 60 + 2000;
   localparam int SEED      = 32'h05f8_e34b;

   logic          clk;
   logic          reset;
   in_word_t      in_word;
   logic          in_wr;
   logic          in_rdy;
   logic          tx_queue_en;
   logic          cpu_q_dma_rd;
   dma_word_t     cpu_q_dma_rd_word;
   logic          cpu_q_dma_pkt_avail;
   tx_q_stats_t   stats;

   dma_word_t     exp_q[$];
   int            model_cnt = 0;
   logic          stored_dly = 1'b0;
   // Marks the final word of a packet on in_wr
   logic          last_wr = 1'b0;
   // Marks a read of a length word on cpu_q_dma_rd
   logic          hdr_read = 1'b0;
   pkt_byte_len_t last_len;
   int            wr_seed;
   int            rd_seed;
   int            errors = 0;
   int            checks = 0;
   int            cycles = 0;

   cpu_dma_tx_top dut (
      .clk                 (clk),
      .reset               (reset),
      .in_word             (in_word),
      .in_wr               (in_wr),
      .in_rdy              (in_rdy),
      .tx_queue_en         (tx_queue_en),
      .cpu_q_dma_rd        (cpu_q_dma_rd),
      .cpu_q_dma_rd_word   (cpu_q_dma_rd_word),
      .cpu_q_dma_pkt_avail (cpu_q_dma_pkt_avail),
      .stats               (stats)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= TIMEOUT) begin
         $display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
         $display("Checks: %0d, errors: %0d", checks, errors);
         $display("Done: errors found");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////
   task automatic check_equal(input string what, input logic [63:0] got,
                              input logic [63:0] exp);
      checks++;
      assert (got == exp) else begin
         errors++;
         $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   // Drive point, 2 ns after the rising edge
   task automatic next_cycle();
      @(posedge clk);
      #2;
   endtask

   // Input byte i goes to DMA byte i mod 4 of half i/4, control bit 7-i likewise
   function automatic dma_word_t dma_half(input in_word_t w, input int half);
      dma_word_t res;
      int        i;
      for (int j = 0; j < 4; j++) begin
         i                = 4 * half + j;
         res.data[8*j +: 8] = w.data[63-8*i -: 8];
         res.ctrl[j]      = w.ctrl[7-i];
      end
      return res;
   endfunction

   // Byte length from 1 to 200
   function automatic pkt_byte_len_t rand_len();
      return pkt_byte_len_t'(1 + ($unsigned($random(wr_seed)) % 200));
   endfunction

   task automatic write_word(input in_word_t w, input logic last);
      logic go;
      go = 1'b0;
      while (!go) begin
         next_cycle();
         go = in_rdy && (($random(wr_seed) & 3) != 0);
         if (!go) begin
            in_wr   = 1'b0;
            last_wr = 1'b0;
         end
      end
      in_word = w;
      in_wr   = 1'b1;
      last_wr = last;
   endtask

   task automatic end_input();
      next_cycle();
      in_wr   = 1'b0;
      last_wr = 1'b0;
   endtask

   task automatic write_packet(input pkt_byte_len_t len);
      in_word_t  w;
      dma_word_t lo;
      int        words;
      int        last_byte;
      words     = (int'(len) + 7) / 8;
      last_byte = (int'(len) - 1) % 8;
      lo.ctrl   = '0;
      lo.data   = 32'(len);
      exp_q.push_back(lo);
      w.ctrl = HDR_CTRL;
      w.data = 64'(len);
      write_word(w, 1'b0);
      for (int k = 0; k < words; k++) begin
         w.data[63:32] = $random(wr_seed);
         w.data[31:0]  = $random(wr_seed);
         w.ctrl        = (k == words - 1) ? (8'h80 >> last_byte) : 8'h00;
         lo            = dma_half(w, 0);
         exp_q.push_back(lo);
         // End marker in half 0, so half 1 is never shown
         if (lo.ctrl == '0) begin
            exp_q.push_back(dma_half(w, 1));
         end
         write_word(w, k == words - 1);
      end
      last_len = len;
   endtask

   task automatic read_packets(input int count);
      dma_word_t exp;
      logic      in_body;
      logic      pause;
      int        done;
      in_body = 1'b0;
      done    = 0;
      while (done < count) begin
         next_cycle();
         cpu_q_dma_rd = 1'b0;
         hdr_read     = 1'b0;
         if (tx_queue_en) begin
            if (($random(rd_seed) & 31) == 0) tx_queue_en = 1'b0;
         end else if (($random(rd_seed) & 3) == 0) begin
            tx_queue_en = 1'b1;
         end
         pause = ($random(rd_seed) & 3) == 0;
         if (!pause && (in_body || (tx_queue_en && (model_cnt != 0)))) begin
            exp = exp_q.pop_front();
            check_equal("DMA word", 64'(cpu_q_dma_rd_word), 64'(exp));
            cpu_q_dma_rd = 1'b1;
            hdr_read     = !in_body;
            if (!in_body) begin
               in_body = 1'b1;
            end else if (exp.ctrl != '0) begin
               in_body = 1'b0;
               done++;
            end
         end
      end
      next_cycle();
      cpu_q_dma_rd = 1'b0;
      hdr_read     = 1'b0;
   endtask

   ////////////////////////////////////////////////////////////
   // Availability model, pkt_count follows a stored word by 2 cycles
   ////////////////////////////////////////////////////////////
   always @(negedge clk) begin
      if (!reset) begin
         check_equal("cpu_q_dma_pkt_avail", 64'(cpu_q_dma_pkt_avail),
                     64'(tx_queue_en && (model_cnt != 0)));
         model_cnt  = model_cnt + int'(stored_dly) - int'(cpu_q_dma_rd && hdr_read);
         stored_dly = in_wr && last_wr;
      end
   end

   initial begin
      wr_seed      = SEED;
      rd_seed      = ~SEED;
      reset        = 1'b1;
      in_word      = '0;
      in_wr        = 1'b0;
      tx_queue_en  = 1'b0;
      cpu_q_dma_rd = 1'b0;
      repeat (8) @(posedge clk);
      #2;
      reset = 1'b0;
      check_equal("in_rdy after reset", 64'(in_rdy), 64'(1));
      check_equal("pkts_stored after reset", 64'(stats.pkts_stored), 64'(0));

      // Fill with the queue disabled and no reads
      for (int p = 0; p < FILL_PKTS; p++) begin
         write_packet(rand_len());
      end
      end_input();
      while (model_cnt != FILL_PKTS) begin
         next_cycle();
      end
      check_equal("in_rdy with 7 packets", 64'(in_rdy), 64'(1));

      // Eighth length fills the length FIFO until the reader pops one
      fork
         begin
            for (int p = FILL_PKTS; p < NUM_PKTS; p++) begin
               write_packet(rand_len());
            end
            end_input();
         end
         read_packets(NUM_PKTS);
      join

      // Counters trail their events by 2 cycles
      repeat (3) next_cycle();
      check_equal("model words left", 64'(exp_q.size()), 64'(0));
      check_equal("pkts_stored", 64'(stats.pkts_stored), 64'(NUM_PKTS));
      check_equal("pkts_removed", 64'(stats.pkts_removed), 64'(NUM_PKTS));
      check_equal("last_byte_len", 64'(stats.last_byte_len), 64'(last_len));
      check_equal("last_word_len", 64'(stats.last_word_len), 64'((int'(last_len) + 7) / 8));
      check_equal("underruns", 64'(stats.underruns), 64'(0));
      check_equal("overruns", 64'(stats.overruns), 64'(0));

      // Reads on the empty queue
      repeat (3) begin
         next_cycle();
         cpu_q_dma_rd = 1'b1;
      end
      next_cycle();
      cpu_q_dma_rd = 1'b0;
      repeat (3) next_cycle();
      check_equal("underruns", 64'(stats.underruns), 64'(3));

      // One header, then 8 words past a full word FIFO
      next_cycle();
      in_word.ctrl = HDR_CTRL;
      in_word.data = 64'(MAX_PKT_SIZE - 1);
      in_wr        = 1'b1;
      for (int k = 0; k < 264; k++) begin
         next_cycle();
         in_word.ctrl = '0;
         in_word.data = 64'(k);
      end
      next_cycle();
      in_wr = 1'b0;
      repeat (3) next_cycle();
      check_equal("overruns", 64'(stats.overruns), 64'(8));

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

// File: project.f
common/cpu_dma_pkg.sv
src/fallthrough_fifo.sv
cpu_dma_tx_queue/tx_word_fifo.sv
cpu_dma_tx_queue/cpu_dma_tx_queue.sv
src/tx_queue_stats.sv
src/cpu_dma_tx_top.sv
test/tb_cpu_dma_tx.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the CPU DMA transmit testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

TOP=tb_cpu_dma_tx
LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
   -f project.f --top-module "$TOP" -o "$TOP"

./obj_dir/"$TOP" 2>&1 | tee "$LOG"

if grep -qx "Done: no errors" "$LOG"; then
   echo "Simulation passed"
else
   echo "Simulation failed, see $LOG"
   exit 1
fi

exit 0
